//--- run.sh
#!/bin/sh
# Build and run with Verilator, result taken from the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f verilog.f --top-module eth_rx_tb -o eth_rx_sim \
	&& ./obj_dir/eth_rx_sim > sim.log 2>&1 \
	|| echo "Errors found" >> sim.log
cat sim.log
grep -q "Errors found" sim.log && exit 1 || exit 0

//--- src/apb_rx_csr.sv
`timescale 1ns/1ps
`default_nettype none

module apb_rx_csr (
	input wire								gmii_rx_clk,
	input wire								rst_n,
	input wire eth_mac_pkg::apb_req_t		apb_req,
	output eth_mac_pkg::apb_rsp_t			apb_rsp,
	output eth_mac_pkg::rx_ctrl_t			ctrl,
	input wire [eth_mac_pkg::CNT_WIDTH-1:0]	cnt_ok,
	input wire [eth_mac_pkg::CNT_WIDTH-1:0]	cnt_crc,
	input wire [eth_mac_pkg::CNT_WIDTH-1:0]	cnt_abort,
	output logic							clr_ok,
	output logic							clr_crc,
	output logic							clr_abort
);
	import eth_mac_pkg::*;

	logic			access;
	logic			wr;
	logic			addr_hit;
	logic [31:0]	rdata;

	////////////////////
	// Decode

	// Access phase, no wait states
	assign access	= apb_req.psel && apb_req.penable;
	assign wr		= access && apb_req.pwrite && addr_hit;

	always_comb begin
		addr_hit = 1'b1;
		rdata    = '0;
		case (apb_req.paddr)
			REG_CTRL:		rdata = {30'h0, ctrl.crc_check_disable, ctrl.rx_enable};
			REG_CNT_OK:		rdata = {{(32 - CNT_WIDTH){1'b0}}, cnt_ok};
			REG_CNT_CRC:	rdata = {{(32 - CNT_WIDTH){1'b0}}, cnt_crc};
			REG_CNT_ABORT:	rdata = {{(32 - CNT_WIDTH){1'b0}}, cnt_abort};
			default:		addr_hit = 1'b0;
		endcase
	end

	// Response
	assign apb_rsp.prdata	= rdata;
	assign apb_rsp.pready	= 1'b1;
	assign apb_rsp.pslverr	= access && !addr_hit;

	////////////////////
	// Registers

	always_ff @(posedge gmii_rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			ctrl.rx_enable			<= 1'b1;
			ctrl.crc_check_disable	<= 1'b0;
			clr_ok					<= 1'b0;
			clr_crc					<= 1'b0;
			clr_abort				<= 1'b0;
		end else begin
			// Any write to a counter clears it, data ignored
			clr_ok		<= wr && (apb_req.paddr == REG_CNT_OK);
			clr_crc		<= wr && (apb_req.paddr == REG_CNT_CRC);
			clr_abort	<= wr && (apb_req.paddr == REG_CNT_ABORT);
			if (wr && apb_req.paddr == REG_CTRL) begin
				ctrl.rx_enable			<= apb_req.pwdata[0];
				ctrl.crc_check_disable	<= apb_req.pwdata[1];
			end
		end
	end

endmodule

`default_nettype wire

//--- src/crc32_eth.sv
`timescale 1ns/1ps
`default_nettype none

module crc32_eth (
	input wire				gmii_rx_clk,
	input wire				rst_n,
	input wire				crc_reset,
	input wire				update,
	input wire [7:0]		din,
	output logic [31:0]		crc
);
	import eth_mac_pkg::*;

	logic [31:0]	crc_next;

	////////////////////
	// Next value

	// Bits go in LSB first, the order they have on the wire
	// Register kept MSB-first, so a good frame leaves CRC_RESIDUE
	always_comb begin
		crc_next = crc;
		for (int i = 0; i < 8; i++) begin
			if (crc_next[31] ^ din[i])
				crc_next = {crc_next[30:0], 1'b0} ^ CRC_POLY;
			else
				crc_next = {crc_next[30:0], 1'b0};
		end
	end

	////////////////////
	// Register

	always_ff @(posedge gmii_rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			crc <= CRC_INIT;
		end else if (crc_reset) begin
			// Reload wins over an update in the same cycle
			crc <= CRC_INIT;
		end else if (update) begin
			crc <= crc_next;
		end
	end

endmodule

`default_nettype wire

//--- src/eth_mac_pkg.sv
`default_nettype none

package eth_mac_pkg;

	////////////////////
	// GMII and frame stream

	// One GMII receive byte time
	typedef struct packed {
		logic		dvalid;
		logic		en;
		logic		er;
		logic [7:0]	data;
	} gmii_bus_t;

	// Frame stream to the upper layer, first byte in data[31:24]
	typedef struct packed {
		logic			start;
		logic			data_valid;
		logic [31:0]	data;
		logic [2:0]		bytes_valid;
		logic			commit;
		logic			drop;
	} eth_rx_bus_t;

	// End-of-frame event pulses for the statistics block
	typedef struct packed {
		logic	frame_ok;
		logic	frame_crc_bad;
		logic	frame_aborted;
	} rx_event_t;

	// Control register fields
	typedef struct packed {
		logic	rx_enable;
		logic	crc_check_disable;
	} rx_ctrl_t;

	////////////////////
	// APB

	typedef struct packed {
		logic			psel;
		logic			penable;
		logic			pwrite;
		logic [7:0]		paddr;
		logic [31:0]	pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0]	prdata;
		logic			pready;
		logic			pslverr;
	} apb_rsp_t;

	////////////////////
	// Constants

	localparam logic [7:0]	PREAMBLE_BYTE	= 8'h55;
	localparam logic [7:0]	SFD_BYTE		= 8'hd5;

	// Register value after a good frame plus its FCS
	localparam logic [31:0]	CRC_INIT		= 32'hffffffff;
	localparam logic [31:0]	CRC_RESIDUE		= 32'hc704dd7b;
	localparam logic [31:0]	CRC_POLY		= 32'h04c11db7;

	// Register map
	localparam logic [7:0]	REG_CTRL		= 8'h00;
	localparam logic [7:0]	REG_CNT_OK		= 8'h04;
	localparam logic [7:0]	REG_CNT_CRC		= 8'h08;
	localparam logic [7:0]	REG_CNT_ABORT	= 8'h0c;

	localparam int			CNT_WIDTH		= 16;

endpackage

`default_nettype wire

//--- src/eth_rx_mac.sv
`timescale 1ns/1ps
`default_nettype none

module eth_rx_mac (
	input wire							gmii_rx_clk,
	input wire							rst_n,
	input wire eth_mac_pkg::gmii_bus_t	gmii_rx_bus,
	input wire							link_up,
	input wire eth_mac_pkg::rx_ctrl_t	ctrl,
	output eth_mac_pkg::eth_rx_bus_t	rx_bus,
	output eth_mac_pkg::rx_event_t		events
);
	import eth_mac_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_PREAMBLE,
		ST_DATA,
		ST_CHECK,
		ST_DISCARD
	} rx_state_t;

	rx_state_t		state;

	// Holdback window, newest byte in the low bits
	logic [31:0]	hold_q;
	logic [2:0]		hold_cnt;
	logic			hold_full;
	logic [7:0]		out_byte;

	// Word packer, bytes that left the window
	logic [23:0]	pack_q;
	logic [1:0]		pack_cnt;

	logic [31:0]	crc;
	logic			crc_reset;
	logic			crc_update;
	logic			take_byte;

	////////////////////
	// FCS check

	// Reload through the whole preamble, SFD included
	assign crc_reset	= (state == ST_PREAMBLE);
	assign crc_update	= gmii_rx_bus.dvalid && gmii_rx_bus.en && (state == ST_DATA);

	crc32_eth crc_i (
		.gmii_rx_clk	(gmii_rx_clk),
		.rst_n			(rst_n),
		.crc_reset		(crc_reset),
		.update			(crc_update),
		.din			(gmii_rx_bus.data),
		.crc			(crc)
	);

	////////////////////
	// Holdback and packing datapath

	// Clean frame byte this cycle
	assign take_byte	= crc_update && !gmii_rx_bus.er && link_up;
	assign hold_full	= (hold_cnt == 3'd4);
	// Oldest byte, pushed out by the incoming one
	assign out_byte		= hold_q[31:24];

	always_ff @(posedge gmii_rx_clk) begin
		if (take_byte) begin
			hold_q <= {hold_q[23:0], gmii_rx_bus.data};
			if (hold_full)
				pack_q <= {pack_q[15:0], out_byte};
		end
	end

	////////////////////
	// Receive FSM

	always_ff @(posedge gmii_rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			state		<= ST_IDLE;
			hold_cnt	<= '0;
			pack_cnt	<= '0;
			rx_bus		<= '0;
			events		<= '0;
		end else begin
			// Every stream field and event is a one-cycle pulse
			rx_bus <= '0;
			events <= '0;

			// Idle GMII cycles between byte strobes change nothing
			if (gmii_rx_bus.dvalid) begin
				case (state)
					ST_IDLE: begin
						if (gmii_rx_bus.en) begin
							if (!ctrl.rx_enable) begin
								// Disabled, skip quietly
								state <= ST_DISCARD;
							end else if (gmii_rx_bus.data == PREAMBLE_BYTE &&
									!gmii_rx_bus.er) begin
								state <= ST_PREAMBLE;
							end else begin
								state					<= ST_DISCARD;
								events.frame_aborted	<= 1'b1;
							end
						end
					end

					ST_PREAMBLE: begin
						if (!gmii_rx_bus.en) begin
							// Carrier lost before the SFD
							state					<= ST_IDLE;
							events.frame_aborted	<= 1'b1;
						end else if (gmii_rx_bus.er) begin
							state					<= ST_DISCARD;
							events.frame_aborted	<= 1'b1;
						end else if (gmii_rx_bus.data == SFD_BYTE) begin
							state			<= ST_DATA;
							hold_cnt		<= '0;
							pack_cnt		<= '0;
							rx_bus.start	<= 1'b1;
						end else if (gmii_rx_bus.data != PREAMBLE_BYTE) begin
							state					<= ST_DISCARD;
							events.frame_aborted	<= 1'b1;
						end
					end

					ST_DATA: begin
						if (!gmii_rx_bus.en) begin
							state <= ST_CHECK;
							// Flush the partial word, window keeps the FCS
							if (hold_full && pack_cnt != 2'd0) begin
								rx_bus.data_valid	<= 1'b1;
								rx_bus.bytes_valid	<= {1'b0, pack_cnt};
								case (pack_cnt)
									2'd1:		rx_bus.data <= {pack_q[7:0], 24'h0};
									2'd2:		rx_bus.data <= {pack_q[15:0], 16'h0};
									default:	rx_bus.data <= {pack_q[23:0], 8'h0};
								endcase
							end
						end else if (gmii_rx_bus.er || !link_up) begin
							// Line error or link loss mid-frame
							state					<= ST_DISCARD;
							rx_bus.drop				<= 1'b1;
							events.frame_aborted	<= 1'b1;
						end else if (!hold_full) begin
							hold_cnt <= hold_cnt + 3'd1;
						end else if (pack_cnt == 2'd3) begin
							// Fourth byte completes the word
							pack_cnt			<= '0;
							rx_bus.data_valid	<= 1'b1;
							rx_bus.bytes_valid	<= 3'd4;
							rx_bus.data			<= {pack_q, out_byte};
						end else begin
							pack_cnt <= pack_cnt + 2'd1;
						end
					end

					ST_CHECK: begin
						state <= ST_IDLE;
						if (!hold_full) begin
							// Runt, not even a whole FCS
							rx_bus.drop				<= 1'b1;
							events.frame_aborted	<= 1'b1;
						end else if (crc == CRC_RESIDUE || ctrl.crc_check_disable) begin
							rx_bus.commit			<= 1'b1;
							events.frame_ok			<= 1'b1;
						end else begin
							rx_bus.drop				<= 1'b1;
							events.frame_crc_bad	<= 1'b1;
						end
					end

					ST_DISCARD: begin
						if (!gmii_rx_bus.en)
							state <= ST_IDLE;
					end

					default: begin
						state <= ST_IDLE;
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- src/eth_rx_top.sv
`timescale 1ns/1ps
`default_nettype none

module eth_rx_top (
	input wire							gmii_rx_clk,
	input wire							rst_n,
	input wire eth_mac_pkg::gmii_bus_t	gmii_rx_bus,
	input wire							link_up,
	output eth_mac_pkg::eth_rx_bus_t	rx_bus,
	input wire eth_mac_pkg::apb_req_t	apb_req,
	output eth_mac_pkg::apb_rsp_t		apb_rsp
);
	import eth_mac_pkg::*;

	rx_ctrl_t				ctrl;
	rx_event_t				events;
	logic [CNT_WIDTH-1:0]	cnt_ok;
	logic [CNT_WIDTH-1:0]	cnt_crc;
	logic [CNT_WIDTH-1:0]	cnt_abort;
	logic					clr_ok;
	logic					clr_crc;
	logic					clr_abort;

	////////////////////
	// Receive MAC

	eth_rx_mac mac_i (
		.gmii_rx_clk	(gmii_rx_clk),
		.rst_n			(rst_n),
		.gmii_rx_bus	(gmii_rx_bus),
		.link_up		(link_up),
		.ctrl			(ctrl),
		.rx_bus			(rx_bus),
		.events			(events)
	);

	////////////////////
	// Frame counters

	rx_frame_stats stats_i (
		.gmii_rx_clk	(gmii_rx_clk),
		.rst_n			(rst_n),
		.events			(events),
		.clr_ok			(clr_ok),
		.clr_crc		(clr_crc),
		.clr_abort		(clr_abort),
		.cnt_ok			(cnt_ok),
		.cnt_crc		(cnt_crc),
		.cnt_abort		(cnt_abort)
	);

	////////////////////
	// APB registers

	apb_rx_csr csr_i (
		.gmii_rx_clk	(gmii_rx_clk),
		.rst_n			(rst_n),
		.apb_req		(apb_req),
		.apb_rsp		(apb_rsp),
		.ctrl			(ctrl),
		.cnt_ok			(cnt_ok),
		.cnt_crc		(cnt_crc),
		.cnt_abort		(cnt_abort),
		.clr_ok			(clr_ok),
		.clr_crc		(clr_crc),
		.clr_abort		(clr_abort)
	);

endmodule

`default_nettype wire

//--- src/rx_frame_stats.sv
`timescale 1ns/1ps
`default_nettype none

module rx_frame_stats (
	input wire									gmii_rx_clk,
	input wire									rst_n,
	input wire eth_mac_pkg::rx_event_t			events,
	input wire									clr_ok,
	input wire									clr_crc,
	input wire									clr_abort,
	output logic [eth_mac_pkg::CNT_WIDTH-1:0]	cnt_ok,
	output logic [eth_mac_pkg::CNT_WIDTH-1:0]	cnt_crc,
	output logic [eth_mac_pkg::CNT_WIDTH-1:0]	cnt_abort
);
	import eth_mac_pkg::*;

	////////////////////
	// Counter rule

	// Saturating step, clear beats count
	// An event in the clear cycle is kept as one
	function automatic logic [CNT_WIDTH-1:0] cnt_next(
		input logic [CNT_WIDTH-1:0]	cnt,
		input logic					ev,
		input logic					clr
	);
		logic [CNT_WIDTH-1:0]	next;
		if (clr)
			next = ev ? CNT_WIDTH'(1) : '0;
		else if (ev && cnt != '1)
			next = cnt + CNT_WIDTH'(1);
		else
			next = cnt;
		return next;
	endfunction

	////////////////////
	// Counters

	always_ff @(posedge gmii_rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt_ok		<= '0;
			cnt_crc		<= '0;
			cnt_abort	<= '0;
		end else begin
			cnt_ok		<= cnt_next(cnt_ok, events.frame_ok, clr_ok);
			cnt_crc		<= cnt_next(cnt_crc, events.frame_crc_bad, clr_crc);
			cnt_abort	<= cnt_next(cnt_abort, events.frame_aborted, clr_abort);
		end
	end

endmodule

`default_nettype wire

//--- tests/eth_rx_assert.sv
`timescale 1ns/1ps
`default_nettype none

module eth_rx_assert (
	input wire							gmii_rx_clk,
	input wire							rst_n,
	input wire eth_mac_pkg::eth_rx_bus_t	rx_bus,
	input wire eth_mac_pkg::apb_req_t	apb_req,
	input wire eth_mac_pkg::apb_rsp_t	apb_rsp
);

	// High from start until the frame's commit or drop
	logic	in_frame;

	always_ff @(posedge gmii_rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			in_frame <= 1'b0;
		end else if (rx_bus.start) begin
			in_frame <= 1'b1;
		end else if (rx_bus.commit || rx_bus.drop) begin
			in_frame <= 1'b0;
		end
	end

	////////////////////
	// Frame stream

	a_commit_drop: assert property (@(posedge gmii_rx_clk) disable iff (!rst_n)
		!(rx_bus.commit && rx_bus.drop))
		else $error("commit and drop high in the same cycle");

	// Words only inside a frame
	a_data_in_frame: assert property (@(posedge gmii_rx_clk) disable iff (!rst_n)
		rx_bus.data_valid |-> in_frame)
		else $error("data_valid outside a frame");

	a_bytes_valid: assert property (@(posedge gmii_rx_clk) disable iff (!rst_n)
		rx_bus.data_valid |-> (rx_bus.bytes_valid != 3'd0 && rx_bus.bytes_valid <= 3'd4))
		else $error("bytes_valid out of range with data_valid high");

	////////////////////
	// APB

	// Zero wait states
	a_pready: assert property (@(posedge gmii_rx_clk) disable iff (!rst_n)
		(apb_req.psel && apb_req.penable) |-> apb_rsp.pready)
		else $error("pready low in the access phase");

endmodule

bind eth_rx_top eth_rx_assert assert_i (
	.gmii_rx_clk	(gmii_rx_clk),
	.rst_n			(rst_n),
	.rx_bus			(rx_bus),
	.apb_req		(apb_req),
	.apb_rsp		(apb_rsp)
);

`default_nettype wire

//--- tests/eth_rx_tb.sv
`timescale 1ns/1ps
`default_nettype none

module eth_rx_tb;
	import eth_mac_pkg::*;

	typedef enum int {FAULT_NONE, FAULT_PREAMBLE, FAULT_EARLY_EN, FAULT_ER, FAULT_LINK} fault_t;
	typedef enum int {END_NONE, END_COMMIT, END_DROP} frame_end_t;

	logic			gmii_rx_clk;
	logic			rst_n;
	gmii_bus_t		gmii_rx_bus;
	logic			link_up;
	eth_rx_bus_t	rx_bus;
	apb_req_t		apb_req;
	apb_rsp_t		apb_rsp;

	integer			seed;
	logic			gap_en;
	// Payload bytes still owed by the DUT, oldest first
	logic [7:0]		exp_q[$];
	int				n_start;
	int				n_commit;
	int				n_drop;
	int				nb;
	logic [31:0]	exp_word;

	tb_clock clk_i (
		.gmii_rx_clk	(gmii_rx_clk),
		.rst_n			(rst_n)
	);

	eth_rx_top dut_i (
		.gmii_rx_clk	(gmii_rx_clk),
		.rst_n			(rst_n),
		.gmii_rx_bus	(gmii_rx_bus),
		.link_up		(link_up),
		.rx_bus			(rx_bus),
		.apb_req		(apb_req),
		.apb_rsp		(apb_rsp)
	);

	////////////////////
	// Helpers

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Errors found");
		$fatal(1, "Simulation stopped");
	endtask

	// Next drive point, 5 ns after the rising edge
	task automatic tick();
		@(posedge gmii_rx_clk);
		#5;
	endtask

	task automatic check_count(input string name, input int got, input int want);
		assert (got == want)
			else stop_on_error($sformatf("[ERROR] %s: got %0h expected %0h", name, got, want));
	endtask

	// Reflected CRC-32, LSB first, poly taken bit-reversed
	function automatic logic [31:0] crc_step(input logic [31:0] c, input logic [7:0] b);
		logic [31:0]	r;
		logic [31:0]	poly_rev;
		for (int i = 0; i < 32; i++)
			poly_rev[i] = CRC_POLY[31 - i];
		r = c ^ {24'h0, b};
		for (int k = 0; k < 8; k++)
			r = r[0] ? ((r >> 1) ^ poly_rev) : (r >> 1);
		return r;
	endfunction

	////////////////////
	// GMII stimulus

	task automatic send_byte(input logic en, input logic er, input logic [7:0] data);
		int	gap;
		// Random idle strobes imitate 10/100 pacing
		gap = gap_en ? int'($unsigned($random(seed)) % 4) : 0;
		repeat (gap) tick();
		gmii_rx_bus.dvalid	= 1'b1;
		gmii_rx_bus.en		= en;
		gmii_rx_bus.er		= er;
		gmii_rx_bus.data	= data;
		tick();
		gmii_rx_bus.dvalid	= 1'b0;
	endtask

	task automatic send_frame(input int len, input logic bad_fcs, input fault_t fault);
		logic [31:0]	c;
		logic [31:0]	fcs;
		logic [7:0]		b;
		int				n_pre;
		exp_q.delete();
		c = CRC_INIT;
		// Carrier drops after three bytes when the preamble is cut short
		n_pre = (fault == FAULT_EARLY_EN) ? 3 : 7;
		for (int i = 0; i < n_pre; i++)
			send_byte(1'b1, 1'b0, (fault == FAULT_PREAMBLE && i == 3) ? 8'h5a : PREAMBLE_BYTE);
		if (fault != FAULT_EARLY_EN) begin
			send_byte(1'b1, 1'b0, SFD_BYTE);
			for (int i = 0; i < len; i++) begin
				b = 8'($random(seed));
				exp_q.push_back(b);
				c = crc_step(c, b);
				// Mid-frame fault on the middle payload byte
				if (fault == FAULT_LINK && i == len / 2)
					link_up = 1'b0;
				send_byte(1'b1, fault == FAULT_ER && i == len / 2, b);
				link_up = 1'b1;
			end
			// FCS goes out low byte first, one bit flipped when corrupted
			fcs = bad_fcs ? (~c ^ 32'h0000_0100) : ~c;
			for (int i = 0; i < 4; i++)
				send_byte(1'b1, 1'b0, fcs[8 * i +: 8]);
		end
		// En low strobes end the frame and let the check run
		repeat (3) send_byte(1'b0, 1'b0, 8'h00);
	endtask

	task automatic run_frame(input int len, input logic bad_fcs, input fault_t fault,
			input frame_end_t end_kind);
		int	starts;
		int	commits;
		int	drops;
		int	waited;
		starts	= n_start;
		commits	= n_commit;
		drops	= n_drop;
		waited	= 0;
		send_frame(len, bad_fcs, fault);
		while (end_kind != END_NONE && n_commit + n_drop == commits + drops) begin
			assert (waited < 64)
				else stop_on_error("Frame end not seen, no commit or drop within 64 cycles");
			tick();
			waited++;
		end
		repeat (4) tick();
		check_count("rx_bus.start", n_start - starts, (end_kind != END_NONE) ? 1 : 0);
		check_count("rx_bus.commit", n_commit - commits, (end_kind == END_COMMIT) ? 1 : 0);
		check_count("rx_bus.drop", n_drop - drops, (end_kind == END_DROP) ? 1 : 0);
		if (end_kind == END_COMMIT)
			check_count("payload bytes not delivered", exp_q.size(), 0);
	endtask

	////////////////////
	// APB stimulus

	task automatic apb_access(input logic write, input logic [7:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata, output logic slverr);
		apb_req.psel	= 1'b1;
		apb_req.penable	= 1'b0;
		apb_req.pwrite	= write;
		apb_req.paddr	= addr;
		apb_req.pwdata	= wdata;
		tick();
		apb_req.penable	= 1'b1;
		// Response is stable mid-cycle of the access phase
		@(negedge gmii_rx_clk);
		rdata	= apb_rsp.prdata;
		slverr	= apb_rsp.pslverr;
		tick();
		apb_req	= '0;
	endtask

	task automatic do_write(input logic [7:0] addr, input logic [31:0] data, input logic want_err);
		logic [31:0]	rdata;
		logic			slverr;
		apb_access(1'b1, addr, data, rdata, slverr);
		check_count($sformatf("apb_rsp.pslverr on write to %02h", addr), int'(slverr),
			int'(want_err));
	endtask

	task automatic check_read(input logic [7:0] addr, input logic [31:0] want,
			input logic want_err);
		logic [31:0]	rdata;
		logic			slverr;
		apb_access(1'b0, addr, 32'h0, rdata, slverr);
		check_count($sformatf("apb_rsp.pslverr on read of %02h", addr), int'(slverr),
			int'(want_err));
		if (!want_err)
			assert (rdata == want)
				else stop_on_error($sformatf("[ERROR] apb_rsp.prdata at %02h: got %08h expected %08h",
					addr, rdata, want));
	endtask

	////////////////////
	// Frame stream monitor

	// Outputs are registered, sampled on the falling edge
	always @(negedge gmii_rx_clk) begin
		if (rst_n) begin
			if (rx_bus.start)
				n_start++;
			if (rx_bus.commit)
				n_commit++;
			if (rx_bus.drop)
				n_drop++;
			if (rx_bus.data_valid) begin
				// First byte in the top bits, unused low bytes zero
				nb = (exp_q.size() < 4) ? exp_q.size() : 4;
				exp_word = '0;
				for (int i = 0; i < nb; i++)
					exp_word[31 - 8 * i -: 8] = exp_q.pop_front();
				assert (rx_bus.bytes_valid == 3'(nb))
					else stop_on_error($sformatf("[ERROR] rx_bus.bytes_valid: got %0h expected %0h",
						rx_bus.bytes_valid, nb));
				assert (rx_bus.data == exp_word)
					else stop_on_error($sformatf("[ERROR] rx_bus.data: got %08h expected %08h",
						rx_bus.data, exp_word));
			end
		end
	end

	////////////////////
	// Watchdog

	initial begin
		int	limit_cycles;
		// 19 frames, 2000 cycles each plus margin
		limit_cycles = 19 * 2000 + 1000;
		repeat (limit_cycles) @(posedge gmii_rx_clk);
		stop_on_error("Timeout, the test sequence did not finish in time");
	end

	////////////////////
	// Test sequence

	initial begin
		int	len;
		seed		= 32'hdb0c4ebf;
		gmii_rx_bus	= '0;
		link_up		= 1'b1;
		apb_req		= '0;
		gap_en		= 1'b0;
		n_start		= 0;
		n_commit	= 0;
		n_drop		= 0;
		wait (rst_n);
		tick();

		// Good frames, odd ones paced with gaps
		for (int i = 0; i < 12; i++) begin
			gap_en = i[0];
			if (i < 4)
				len = 4 + i;
			else if (i == 4)
				len = 70;
			else
				len = 4 + int'($unsigned($random(seed)) % 67);
			run_frame(len, 1'b0, FAULT_NONE, END_COMMIT);
		end
		check_read(REG_CNT_OK, 32'd12, 1'b0);
		check_read(REG_CNT_CRC, 32'd0, 1'b0);
		check_read(REG_CNT_ABORT, 32'd0, 1'b0);

		// Corrupted FCS, then the same with the check bypassed
		run_frame(20, 1'b1, FAULT_NONE, END_DROP);
		check_read(REG_CNT_CRC, 32'd1, 1'b0);
		do_write(REG_CTRL, 32'h3, 1'b0);
		run_frame(20, 1'b1, FAULT_NONE, END_COMMIT);
		check_read(REG_CNT_OK, 32'd13, 1'b0);
		check_read(REG_CTRL, 32'h3, 1'b0);
		do_write(REG_CTRL, 32'h1, 1'b0);

		// Preamble faults never show a start
		run_frame(16, 1'b0, FAULT_PREAMBLE, END_NONE);
		run_frame(16, 1'b0, FAULT_EARLY_EN, END_NONE);
		check_read(REG_CNT_ABORT, 32'd2, 1'b0);

		// Mid-frame line error and link loss
		gap_en = 1'b1;
		run_frame(40, 1'b0, FAULT_ER, END_DROP);
		run_frame(40, 1'b0, FAULT_LINK, END_DROP);
		gap_en = 1'b0;
		check_read(REG_CNT_ABORT, 32'd4, 1'b0);
		check_read(REG_CNT_OK, 32'd13, 1'b0);
		check_read(REG_CNT_CRC, 32'd1, 1'b0);

		// Receiver disabled, frame ignored and not counted
		do_write(REG_CTRL, 32'h0, 1'b0);
		run_frame(20, 1'b0, FAULT_NONE, END_NONE);
		check_read(REG_CNT_OK, 32'd13, 1'b0);
		check_read(REG_CNT_CRC, 32'd1, 1'b0);
		check_read(REG_CNT_ABORT, 32'd4, 1'b0);
		do_write(REG_CTRL, 32'h1, 1'b0);

		// Clear on write, any data
		do_write(REG_CNT_OK, 32'hffffffff, 1'b0);
		do_write(REG_CNT_CRC, 32'hffffffff, 1'b0);
		do_write(REG_CNT_ABORT, 32'hffffffff, 1'b0);
		check_read(REG_CNT_OK, 32'd0, 1'b0);
		check_read(REG_CNT_CRC, 32'd0, 1'b0);
		check_read(REG_CNT_ABORT, 32'd0, 1'b0);

		// Unmapped address errors out and leaves ctrl alone
		do_write(8'h10, 32'h2, 1'b1);
		check_read(8'h10, 32'h0, 1'b1);
		check_read(REG_CTRL, 32'h1, 1'b0);

		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- tests/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic	gmii_rx_clk,
	output logic	rst_n
);

	// 10 MHz byte clock, 100 ns period
	initial begin
		gmii_rx_clk = 1'b0;
		forever #50 gmii_rx_clk = ~gmii_rx_clk;
	end

	// Reset held for 16 cycles, released clear of the edge
	initial begin
		rst_n = 1'b0;
		repeat (16) @(posedge gmii_rx_clk);
		#5 rst_n = 1'b1;
	end

endmodule

`default_nettype wire

//--- verilog.f
src/eth_mac_pkg.sv
src/crc32_eth.sv
src/eth_rx_mac.sv
src/rx_frame_stats.sv
src/apb_rx_csr.sv
src/eth_rx_top.sv
tests/tb_clock.sv
tests/eth_rx_assert.sv
tests/eth_rx_tb.sv
